// ==== hw/cop_pkg.sv ====
/* Private encoding under the custom-0 major opcode. Function values above 4'h6 are illegal.
   There are no immediates and no memory forms. */
`default_nettype none

package cop_pkg;

    localparam logic [6:0] COP_OPCODE = 7'b0001011;    // custom-0

    // Encoding field positions
    localparam int OPC_LSB  = 0;                        // Major opcode
    localparam int OPC_W    = 7;
    localparam int RD_LSB   = 7;                        // GPR destination
    localparam int RD_W     = 5;
    localparam int CRD_LSB  = 7;                        // CPR destination, overlaps rd
    localparam int CRS1_LSB = 15;
    localparam int CRS2_LSB = 20;
    localparam int CPR_AW   = 4;                        // Sixteen CPRs
    localparam int PW_LSB   = 25;                       // Pack width
    localparam int PW_W     = 2;
    localparam int FN_LSB   = 28;                       // Function field
    localparam int FN_W     = 4;

    typedef enum logic [3:0] {
        OP_GPR2XCR = 4'h0,                              // rs1 -> crd
        OP_XCR2GPR = 4'h1,                              // crs1 -> rd
        OP_PADD    = 4'h2,
        OP_PSUB    = 4'h3,
        OP_AND     = 4'h4,
        OP_OR      = 4'h5,
        OP_XOR     = 4'h6
    } cop_op_e;

    typedef enum logic [1:0] {
        PW_32 = 2'd0,
        PW_16 = 2'd1,
        PW_8  = 2'd2,
        PW_4  = 2'd3
    } cop_pw_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WAITING   = 2'd1,
        ST_EXECUTING = 2'd2,
        ST_FINISHED  = 2'd3
    } cop_state_e;

    typedef logic [2:0] cop_res_t;

    localparam cop_res_t RES_SUCCESS = 3'd0;
    localparam cop_res_t RES_BAD_INS = 3'd1;

    typedef struct packed {
        cop_op_e     op;
        cop_pw_e     pw;
        logic [3:0]  crd;
        logic [3:0]  crs1;
        logic [3:0]  crs2;
        logic [4:0]  rd;
        logic        illegal;                           // Bad opcode or function
    } cop_dec_t;

    typedef struct packed {
        logic        cpr_wen;
        logic [3:0]  cpr_addr;
        logic [31:0] cpr_wdata;
        logic        gpr_wen;                           // Legal XCR2GPR only
        logic [31:0] gpr_wdata;
        logic        illegal;
        logic [4:0]  rd;
    } cop_wb_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        cop_res_t    result;
    } cop_rsp_t;

endpackage

`default_nettype wire

// ==== hw/cop_regfile.sv ====
/* Sixteen CPRs, all cleared by reset. Reads are combinational, so a write is
   visible to a read only in the cycle after its edge. */
`timescale 1ns/1ps
`default_nettype none

module cop_regfile (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic [3:0]  rs1_addr,
    input  logic [3:0]  rs2_addr,
    input  logic        wen,
    input  logic [3:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] cprs [16];

    assign rs1_data = cprs[rs1_addr];                   // Async read ports
    assign rs2_data = cprs[rs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 16; i++) begin
                cprs[i] <= '0;
            end
        end else if (wen) begin
            cprs[waddr] <= wdata;
        end
    end

    // A write must target a known register
    a_waddr_known: assert property (@(posedge g_clk) disable iff (!g_resetn)
        wen |-> !$isunknown(waddr));

endmodule

`default_nettype wire

// ==== hw/cop_control.sv ====
/* One instruction in flight. The response follows acceptance by exactly two cycles
   and is held until the CPU acknowledges it. */
`timescale 1ns/1ps
`default_nettype none

module cop_control (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        cpu_insn_req,
    input  logic [31:0] cpu_insn_enc,
    input  logic [31:0] cpu_rs1,
    input  logic        cpu_insn_ack,
    input  logic        exe_done,
    output logic        cop_insn_ack,
    output logic        cop_insn_rsp,
    output logic [31:0] insn_enc,
    output logic [31:0] gpr_rs1,
    output logic        issue
);
    import cop_pkg::*;

    cop_state_e state;
    cop_state_e n_state;
    logic       n_ack;
    logic       n_rsp;
    logic       accept;
    logic       retire;

    assign accept = cpu_insn_req && cop_insn_ack;        // Edge E0
    assign retire = cop_insn_rsp && cpu_insn_ack;

    always_comb begin
        n_state = state;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            ST_IDLE: begin
                n_state = ST_WAITING;                   // Leave reset
                n_ack   = 1'b1;
            end
            ST_WAITING: begin
                if (accept) begin
                    n_state = ST_EXECUTING;
                end else begin
                    n_ack = 1'b1;                       // Keep offering
                end
            end
            ST_EXECUTING: begin
                if (exe_done) begin
                    n_state = ST_FINISHED;              // Edge E2
                    n_rsp   = 1'b1;
                end
            end
            ST_FINISHED: begin
                if (retire) begin
                    n_state = ST_WAITING;
                    n_ack   = 1'b1;
                end else begin
                    n_rsp = 1'b1;                       // CPU back-pressure
                end
            end
            default: n_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= ST_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            issue        <= 1'b0;
        end else begin
            state        <= n_state;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
            issue        <= accept;                     // First EXECUTING cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            insn_enc <= cpu_insn_enc;                   // Held for decode
            gpr_rs1  <= cpu_rs1;
        end
    end

    // Handshake strobes are mutually exclusive
    a_ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp));

    // Execute completion only while an instruction is in flight
    a_done_in_exec: assert property (@(posedge g_clk) disable iff (!g_resetn)
        exe_done |-> state == ST_EXECUTING);

endmodule

`default_nettype wire

// ==== hw/cop_decode.sv ====
/* Purely combinational. Bits 27 and 24 and the unused register bits are ignored,
   so only the major opcode and the function field make an encoding illegal. */
`timescale 1ns/1ps
`default_nettype none

module cop_decode (
    input  logic [31:0]       insn_enc,
    output cop_pkg::cop_dec_t dec
);
    import cop_pkg::*;

    logic [OPC_W-1:0] major;
    logic [FN_W-1:0]  fn;
    logic             bad_major;
    logic             bad_fn;
    cop_op_e          op;

    assign major = insn_enc[OPC_LSB +: OPC_W];
    assign fn    = insn_enc[FN_LSB +: FN_W];

    assign bad_major = (major != COP_OPCODE);           // Not custom-0

    // Function field onto the opcode enum
    always_comb begin
        bad_fn = 1'b0;
        op     = OP_GPR2XCR;                            // Harmless default
        case (fn)
            OP_GPR2XCR,
            OP_XCR2GPR,
            OP_PADD,
            OP_PSUB,
            OP_AND,
            OP_OR,
            OP_XOR: begin
                op = cop_op_e'(fn);
            end
            default: begin
                bad_fn = 1'b1;                          // 7..15 unassigned
            end
        endcase
    end

    always_comb begin
        dec.op      = op;
        dec.pw      = cop_pw_e'(insn_enc[PW_LSB +: PW_W]);
        dec.crd     = insn_enc[CRD_LSB +: CPR_AW];
        dec.crs1    = insn_enc[CRS1_LSB +: CPR_AW];
        dec.crs2    = insn_enc[CRS2_LSB +: CPR_AW];
        dec.rd      = insn_enc[RD_LSB +: RD_W];
        dec.illegal = bad_major || bad_fn;              // Sole legality check
    end

endmodule

`default_nettype wire

// ==== hw/cop_execute.sv ====
/* Single-cycle execute stage. The CPR write is issued from the registered result,
   so it lands one edge after done rises. */
`timescale 1ns/1ps
`default_nettype none

module cop_execute (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              issue,
    input  cop_pkg::cop_dec_t dec,
    input  logic [31:0]       gpr_rs1,
    output logic              done,
    output cop_pkg::cop_wb_t  wb
);
    import cop_pkg::*;

    logic [31:0] crs1_data;
    logic [31:0] crs2_data;
    cop_wb_t     n_wb;

    // Packed add or subtract with the carry chain cut at each lane start
    function automatic logic [31:0] lane_addsub(
        input logic [31:0] a,
        input logic [31:0] b,
        input logic        sub,
        input cop_pw_e     pw
    );
        logic [31:0] bx;
        logic [31:0] sum;
        logic [2:0]  mask;
        logic        carry;
        logic [4:0]  nib;
        bx = sub ? ~b : b;                              // a + ~b + 1
        case (pw)
            PW_32:   mask = 3'b111;
            PW_16:   mask = 3'b011;
            PW_8:    mask = 3'b001;
            default: mask = 3'b000;                     // Every nibble a lane
        endcase
        carry = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if ((3'(i) & mask) == 3'b000) begin
                carry = sub;                            // Fresh lane
            end
            nib = {1'b0, a[i*4 +: 4]} + {1'b0, bx[i*4 +: 4]} + {4'b0, carry};
            sum[i*4 +: 4] = nib[3:0];
            carry = nib[4];
        end
        return sum;
    endfunction

    cop_regfile u_regfile (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs1_addr (dec.crs1),
        .rs2_addr (dec.crs2),
        .wen      (done && wb.cpr_wen),                 // Only the registered result
        .waddr    (wb.cpr_addr),
        .wdata    (wb.cpr_wdata),
        .rs1_data (crs1_data),
        .rs2_data (crs2_data)
    );

    always_comb begin
        n_wb          = '0;
        n_wb.cpr_addr = dec.crd;
        n_wb.rd       = dec.rd;
        n_wb.illegal  = dec.illegal;
        case (dec.op)
            OP_GPR2XCR: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = gpr_rs1;
            end
            OP_XCR2GPR: begin
                n_wb.gpr_wen   = 1'b1;
                n_wb.gpr_wdata = crs1_data;
            end
            OP_PADD: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = lane_addsub(crs1_data, crs2_data, 1'b0, dec.pw);
            end
            OP_PSUB: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = lane_addsub(crs1_data, crs2_data, 1'b1, dec.pw);
            end
            OP_AND: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = crs1_data & crs2_data;
            end
            OP_OR: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = crs1_data | crs2_data;
            end
            OP_XOR: begin
                n_wb.cpr_wen   = 1'b1;
                n_wb.cpr_wdata = crs1_data ^ crs2_data;
            end
            default: ;
        endcase
        if (dec.illegal) begin
            n_wb.cpr_wen = 1'b0;                        // No side effects
            n_wb.gpr_wen = 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done <= 1'b0;
        end else begin
            done <= issue;                              // Edge E1
        end
    end

    always_ff @(posedge g_clk) begin
        if (issue) begin
            wb <= n_wb;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cop_result.sv ====
/* Response register towards the CPU. Values persist until the next completion,
   which covers any length of CPU back-pressure. */
`timescale 1ns/1ps
`default_nettype none

module cop_result (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              exe_done,
    input  cop_pkg::cop_wb_t  wb,
    output cop_pkg::cop_rsp_t rsp
);
    import cop_pkg::*;

    cop_rsp_t n_rsp;

    always_comb begin
        n_rsp.wen    = wb.gpr_wen && !wb.illegal;       // XCR2GPR only
        n_rsp.waddr  = wb.rd;
        n_rsp.wdata  = wb.gpr_wdata;
        n_rsp.result = wb.illegal ? RES_BAD_INS : RES_SUCCESS;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp.wen    <= 1'b0;
            rsp.waddr  <= '0;
            rsp.wdata  <= '0;
            rsp.result <= RES_SUCCESS;
        end else if (exe_done) begin
            rsp <= n_rsp;                               // Edge E2
        end
    end

    // Response outputs move only on a completion
    a_rsp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !$stable(rsp) |-> $past(exe_done));

endmodule

`default_nettype wire

// ==== hw/cop_top.sv ====
/* Co-processor top level. Plain request/acknowledge strobes on both sides, one
   instruction at a time, fixed two-cycle latency from accept to response. */
`timescale 1ns/1ps
`default_nettype none

module cop_top (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        cpu_insn_req,
    input  logic [31:0] cpu_insn_enc,
    input  logic [31:0] cpu_rs1,
    input  logic        cpu_insn_ack,
    output logic        cop_insn_ack,
    output logic        cop_insn_rsp,
    output logic        cop_wen,
    output logic [4:0]  cop_waddr,
    output logic [31:0] cop_wdata,
    output logic [2:0]  cop_result
);
    import cop_pkg::*;

    logic [31:0] insn_enc;                              // Captured encoding
    logic [31:0] gpr_rs1;                               // Captured rs1
    logic        issue;
    logic        exe_done;
    cop_dec_t    dec;
    cop_wb_t     wb;
    cop_rsp_t    rsp;

    cop_control u_control (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .exe_done     (exe_done),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .insn_enc     (insn_enc),
        .gpr_rs1      (gpr_rs1),
        .issue        (issue)
    );

    cop_decode u_decode (
        .insn_enc (insn_enc),
        .dec      (dec)
    );

    cop_execute u_execute (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .issue    (issue),
        .dec      (dec),
        .gpr_rs1  (gpr_rs1),
        .done     (exe_done),
        .wb       (wb)
    );

    cop_result u_result (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .exe_done (exe_done),
        .wb       (wb),
        .rsp      (rsp)
    );

    assign cop_wen    = rsp.wen;                        // Unpack response
    assign cop_waddr  = rsp.waddr;
    assign cop_wdata  = rsp.wdata;
    assign cop_result = rsp.result;

endmodule

`default_nettype wire

// ==== bench/tb_cop.sv ====
/* Drives cop_top one instruction at a time and predicts each response from a shadow CPR array.
   Response fields waddr and wdata are only compared when a GPR write is expected. */
`timescale 1ns/1ps
`default_nettype none

module tb_cop;
    import cop_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int PK_REPS    = 3;                      // Per pack width and add/sub
    localparam int BW_REPS    = 4;                      // Per bitwise op
    localparam int IL_REPS    = 4;                      // Per illegal kind
    localparam int BP_REPS    = 4;
    localparam int N_INSNS    = 32 + 4 * 2 * PK_REPS * 4 + 3 * BW_REPS * 4
                                + 16 + 2 * IL_REPS * 2 + BP_REPS * 2;

    logic        g_clk;
    logic        g_resetn;
    logic        cpu_insn_req;
    logic [31:0] cpu_insn_enc;
    logic [31:0] cpu_rs1;
    logic        cpu_insn_ack;
    logic        cop_insn_ack;
    logic        cop_insn_rsp;
    logic        cop_wen;
    logic [4:0]  cop_waddr;
    logic [31:0] cop_wdata;
    logic [2:0]  cop_result;

    logic [31:0] shadow [16];                           // Expected CPR contents
    logic [31:0] lfsr;
    cop_rsp_t    exp_q [$];                             // One entry per instruction in flight
    cop_rsp_t    head;
    int          errors;
    int          n_checks;
    int          n_issued;
    int          n_retired;
    int          tests_run;
    int          tests_failed;

    cop_top UUT (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // Taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_enc(input logic [6:0] major, input logic [3:0] fn,
                                             input logic [1:0] pw, input logic [3:0] c2,
                                             input logic [3:0] c1, input logic [4:0] rd);
        return {fn, 1'b0, pw, 1'b0, c2, 1'b0, c1, 3'b000, rd, major};
    endfunction

    // Lane by lane in wide arithmetic so the mask drops each carry
    function automatic logic [31:0] lane_ref(input logic [31:0] a, input logic [31:0] b,
                                             input logic sub, input logic [1:0] pw);
        int          w;
        logic [63:0] m;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] acc;
        w   = 32 >> pw;                                 // 32, 16, 8 or 4
        m   = (64'd1 << w) - 64'd1;
        acc = '0;
        for (int l = 0; l < 32 / w; l++) begin
            la  = ({32'b0, a} >> (l * w)) & m;
            lb  = ({32'b0, b} >> (l * w)) & m;
            acc = acc | ((sub ? (la - lb) : (la + lb)) & m) << (l * w);
        end
        return acc[31:0];
    endfunction

    // Expected response plus the CPR update applied to the shadow array
    function automatic cop_rsp_t ref_exec(input logic [31:0] enc, input logic [31:0] rs1);
        cop_rsp_t   r;
        logic [3:0] fn;
        logic [3:0] crd;
        logic [3:0] c1;
        logic [3:0] c2;
        logic [1:0] pw;
        logic       legal;
        fn    = enc[31:28];
        crd   = enc[10:7];
        c1    = enc[18:15];
        c2    = enc[23:20];
        pw    = enc[26:25];
        legal = (enc[6:0] == COP_OPCODE);
        r       = '0;
        r.waddr = enc[11:7];
        case (fn)
            OP_GPR2XCR: if (legal) shadow[crd] = rs1;
            OP_XCR2GPR: begin
                r.wen   = legal;
                r.wdata = shadow[c1];
            end
            OP_PADD:    if (legal) shadow[crd] = lane_ref(shadow[c1], shadow[c2], 1'b0, pw);
            OP_PSUB:    if (legal) shadow[crd] = lane_ref(shadow[c1], shadow[c2], 1'b1, pw);
            OP_AND:     if (legal) shadow[crd] = shadow[c1] & shadow[c2];
            OP_OR:      if (legal) shadow[crd] = shadow[c1] | shadow[c2];
            OP_XOR:     if (legal) shadow[crd] = shadow[c1] ^ shadow[c2];
            default:    legal = 1'b0;                   // Unassigned function
        endcase
        r.result = legal ? RES_SUCCESS : RES_BAD_INS;
        return r;
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Starts and returns just after a falling edge; hold delays the CPU ack
    task automatic run_insn(input logic [31:0] enc, input logic [31:0] rs1, input int hold);
        int          lat;
        logic [40:0] snap;
        exp_q.push_back(ref_exec(enc, rs1));
        n_issued++;
        while (!cop_insn_ack) @(negedge g_clk);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        @(negedge g_clk);                               // Accepted on the edge before
        cpu_insn_req = 1'b0;
        lat = 0;
        while (!cop_insn_rsp && lat < 8) begin
            @(negedge g_clk);
            lat++;
        end
        check("accept to response cycles", lat, 2);
        snap = {cop_wen, cop_waddr, cop_wdata, cop_result};
        cpu_insn_req = (hold > 0);                      // Try a second instruction meanwhile
        cpu_insn_enc = make_enc(COP_OPCODE, OP_GPR2XCR, 2'd0, 4'd0, 4'd0, 5'd15);
        cpu_rs1      = 32'hDEAD_BEEF;
        repeat (hold) begin
            @(negedge g_clk);
            check("rsp held", cop_insn_rsp, 1'b1);
            check("no accept while held", cop_insn_ack, 1'b0);
            check("outputs held", {cop_wen, cop_waddr, cop_wdata, cop_result}, snap);
        end
        cpu_insn_req = 1'b0;
        cpu_insn_ack = 1'b1;
        @(negedge g_clk);                               // Retired on the edge before
        cpu_insn_ack = 1'b0;
        check("rsp after retire", cop_insn_rsp, 1'b0);
        check("ack after retire", cop_insn_ack, 1'b1);
    endtask

    task automatic load_cpr(input logic [3:0] idx, input logic [31:0] val, input int hold);
        run_insn(make_enc(COP_OPCODE, OP_GPR2XCR, 2'd0, 4'd0, 4'd0, {1'b0, idx}), val, hold);
    endtask

    task automatic read_cpr(input logic [3:0] idx, input int hold);
        run_insn(make_enc(COP_OPCODE, OP_XCR2GPR, 2'd0, 4'd0, idx, 5'(rand_bits(5))), '0, hold);
    endtask

    task automatic end_test(input string name, input int base);
        tests_run++;
        if (errors != base) tests_failed++;
        $display("test %-14s %s (%0d errors)", name, (errors == base) ? "ok" : "failed",
                 errors - base);
    endtask

    // Compare on every retire edge using the values from before the edge
    always @(posedge g_clk) begin
        if (g_resetn && cop_insn_rsp && cpu_insn_ack) begin
            n_retired++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: response with no instruction outstanding", $time);
            end else begin
                head = exp_q.pop_front();
                check("cop_result", cop_result, head.result);
                check("cop_wen", cop_wen, head.wen);
                if (head.wen) begin
                    check("cop_waddr", cop_waddr, head.waddr);
                    check("cop_wdata", cop_wdata, head.wdata);
                end
            end
        end
    end

    initial begin
        #(N_INSNS * 40 * CLK_PERIOD);
        $display("Timeout: the DUT stopped handshaking before all tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int          base;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [31:0] va;
        logic [31:0] vb;
        logic [6:0]  major;
        logic [3:0]  fn;
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        lfsr         = 32'd41;
        errors       = 0;
        n_checks     = 0;
        n_issued     = 0;
        n_retired    = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 16; i++) shadow[i] = '0;   // CPRs clear on reset

        base = errors;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        check("ack in reset", cop_insn_ack, 1'b0);
        check("rsp in reset", cop_insn_rsp, 1'b0);
        g_resetn = 1'b1;
        @(negedge g_clk);
        check("ack after reset", cop_insn_ack, 1'b1);
        check("rsp after reset", cop_insn_rsp, 1'b0);
        check("wen after reset", cop_wen, 1'b0);
        check("result after reset", cop_result, RES_SUCCESS);
        end_test("reset", base);

        base = errors;
        for (int i = 0; i < 16; i++) load_cpr(4'(i), rand_bits(32), 0);
        for (int i = 0; i < 16; i++) read_cpr(4'(i), 0);
        end_test("move", base);

        base = errors;
        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < PK_REPS; k++) begin
                    ra = 4'(rand_bits(4));
                    rb = 4'(rand_bits(4));
                    rc = 4'(rand_bits(4));
                    if (rb == ra) rb = ~ra;             // Two distinct source CPRs
                    // First pass carries or borrows out of every lane
                    if (k == 0) begin
                        va = (s == 1) ? 32'h0000_0000 : 32'hFFFF_FFFF;
                        vb = 32'h1111_1111;
                    end else begin
                        va = rand_bits(32);
                        vb = rand_bits(32);
                    end
                    load_cpr(ra, va, 0);
                    load_cpr(rb, vb, 0);
                    run_insn(make_enc(COP_OPCODE, (s == 1) ? OP_PSUB : OP_PADD, 2'(p), rb, ra,
                                      {1'b0, rc}), '0, 0);
                    read_cpr(rc, 0);
                end
            end
        end
        end_test("packed add/sub", base);

        base = errors;
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < BW_REPS; j++) begin
                ra = 4'(rand_bits(4));
                rb = 4'(rand_bits(4));
                rc = 4'(rand_bits(4));
                load_cpr(ra, rand_bits(32), 0);
                load_cpr(rb, rand_bits(32), 0);
                fn = (k == 0) ? OP_AND : (k == 1) ? OP_OR : OP_XOR;
                run_insn(make_enc(COP_OPCODE, fn, 2'd0, rb, ra, {1'b0, rc}), '0, 0);
                read_cpr(rc, 0);
            end
        end
        end_test("bitwise", base);

        base = errors;
        for (int i = 0; i < 16; i++) load_cpr(4'(i), 32'hA5A5_0000 + i * 32'h0101, 0);
        for (int j = 0; j < IL_REPS; j++) begin
            major = 7'(rand_bits(7));
            if (major == COP_OPCODE) major = major ^ 7'h20; // Never custom-0
            fn = 4'(rand_bits(3) % 7);                  // Otherwise legal function
            rc = 4'(rand_bits(4));
            run_insn(make_enc(major, fn, 2'(rand_bits(2)), 4'(rand_bits(4)), 4'(rand_bits(4)),
                              {1'b0, rc}), rand_bits(32), 0);
            read_cpr(rc, 0);
            fn = 4'd7 + 4'(rand_bits(4) % 9);           // 7 to 15
            rc = 4'(rand_bits(4));
            run_insn(make_enc(COP_OPCODE, fn, 2'(rand_bits(2)), 4'(rand_bits(4)),
                              4'(rand_bits(4)), {1'b0, rc}), rand_bits(32), 0);
            read_cpr(rc, 0);
        end
        end_test("illegal", base);

        base = errors;
        for (int j = 0; j < BP_REPS; j++) begin
            ra = 4'(rand_bits(4));
            rb = 4'(rand_bits(4));
            rc = 4'(rand_bits(4));
            run_insn(make_enc(COP_OPCODE, (j % 2 == 1) ? OP_XOR : OP_PADD, 2'(rand_bits(2)), rb,
                              ra, {1'b0, rc}), '0, 1 + int'(rand_bits(4)));
            read_cpr(rc, 1 + int'(rand_bits(4)));
        end
        end_test("back-pressure", base);

        check("responses per instruction", n_retired, n_issued);
        check("instructions left outstanding", exp_q.size(), 0);
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 n_checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/cop_pkg.sv
hw/cop_regfile.sv
hw/cop_control.sv
hw/cop_decode.sv
hw/cop_execute.sv
hw/cop_result.sv
hw/cop_top.sv
bench/tb_cop.sv

// ==== Bender.yml ====
package:
  name: cop

sources:
  - files:
      - hw/cop_pkg.sv
      - hw/cop_regfile.sv
      - hw/cop_control.sv
      - hw/cop_decode.sv
      - hw/cop_execute.sv
      - hw/cop_result.sv
      - hw/cop_top.sv
  - target: test
    files:
      - bench/tb_cop.sv
